/* src/ddr_cmd_pkg.sv */
// shared definitions for the ddr command generator
// default memory geometry, csr field widths, beat and burst constants
// address order and command size types

`default_nettype none

package ddr_cmd_pkg;

    ////////////////////////////////////////
    // default geometry for the top level
    ////////////////////////////////////////
    localparam int DEF_COL_WIDTH        = 12;
    localparam int DEF_ROW_WIDTH        = 16;
    localparam int DEF_BANK_WIDTH       = 3;
    localparam int DEF_CHIP_BITS        = 2;
    localparam int DEF_LOCAL_ADDR_WIDTH = 33;

    ////////////////////////////////////////
    // fixed widths and ratios
    ////////////////////////////////////////
    localparam int SIZE_WIDTH      = 6;  // local request size in beats
    localparam int CSR_COL_WIDTH   = 4;
    localparam int CSR_ROW_WIDTH   = 5;
    localparam int CSR_BANK_WIDTH  = 2;
    localparam int CSR_CS_WIDTH    = 2;
    localparam int BEAT_SHIFT      = 2;  // one local beat is 4 columns
    localparam int BURST_SHIFT     = 3;  // one burst of 8 is 8 columns
    localparam int BEATS_PER_BURST = 2;

    // bit offsets into the local address, largest is 15 + 31 + 3 - 2
    localparam int OFS_WIDTH = 6;

    // field order of the local address, top down
    typedef enum logic [0:0] {
        ORDER_ROW_BANK = 1'b0,  // chip, row, bank, column
        ORDER_BANK_ROW = 1'b1   // chip, bank, row, column
    } addr_order_t;

    typedef logic [1:0] cmd_size_t;  // local beats in one command, 1 or 2

endpackage

`default_nettype wire

/* src/csr_geometry.sv */
// csr_geometry
// registers where each address field starts in the local address,
// the all-ones maximum of each field and the chip field flag

`default_nettype none

module csr_geometry #(
    parameter int col_width  = ddr_cmd_pkg::DEF_COL_WIDTH,
    parameter int row_width  = ddr_cmd_pkg::DEF_ROW_WIDTH,
    parameter int bank_width = ddr_cmd_pkg::DEF_BANK_WIDTH,
    parameter int chip_bits  = ddr_cmd_pkg::DEF_CHIP_BITS
) (
    input  wire logic                                   ctl_clk,
    input  wire logic                                   ctl_reset_n,
    input  wire logic [ddr_cmd_pkg::CSR_COL_WIDTH-1:0]  col_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_ROW_WIDTH-1:0]  row_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_BANK_WIDTH-1:0] bank_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_CS_WIDTH-1:0]   cs_width_csr,
    output logic [ddr_cmd_pkg::OFS_WIDTH-1:0]           col_offset,
    output logic [ddr_cmd_pkg::OFS_WIDTH-1:0]           col_row_offset,
    output logic [ddr_cmd_pkg::OFS_WIDTH-1:0]           col_bank_offset,
    output logic [ddr_cmd_pkg::OFS_WIDTH-1:0]           chip_offset,
    output logic [col_width-1:0]                        max_col,
    output logic [row_width-1:0]                        max_row,
    output logic [bank_width-1:0]                       max_bank,
    output logic [chip_bits-1:0]                        max_chip,
    output logic                                        cs_present
);
    import ddr_cmd_pkg::*;

    logic [OFS_WIDTH-1:0] col_w;   // column bits held in the local address
    logic [OFS_WIDTH-1:0] row_w;
    logic [OFS_WIDTH-1:0] bank_w;

    assign col_w  = OFS_WIDTH'(col_width_csr) - OFS_WIDTH'(BEAT_SHIFT);
    assign row_w  = OFS_WIDTH'(row_width_csr);
    assign bank_w = OFS_WIDTH'(bank_width_csr);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            col_offset      <= '0;
            col_row_offset  <= '0;
            col_bank_offset <= '0;
            chip_offset     <= '0;
            max_col         <= '0;
            max_row         <= '0;
            max_bank        <= '0;
            max_chip        <= '0;
            cs_present      <= 1'b0;
        end
        else
        begin
            col_offset      <= col_w;
            col_row_offset  <= col_w + row_w;
            col_bank_offset <= col_w + bank_w;
            chip_offset     <= col_w + row_w + bank_w;
            // low w bits set, fields narrower than the csr width saturate
            max_col         <= col_width'(~(32'hffff_ffff << col_width_csr));
            max_row         <= row_width'(~(32'hffff_ffff << row_width_csr));
            max_bank        <= bank_width'(~(32'hffff_ffff << bank_width_csr));
            max_chip        <= chip_bits'(~(32'hffff_ffff << cs_width_csr));
            cs_present      <= (cs_width_csr != '0);
        end
    end

endmodule

`default_nettype wire

/* src/addr_mapper.sv */
// addr_mapper
// combinational split of the flat local beat address into
// chip, bank, row and column fields for either address order

`default_nettype none

module addr_mapper #(
    parameter int col_width        = ddr_cmd_pkg::DEF_COL_WIDTH,
    parameter int row_width        = ddr_cmd_pkg::DEF_ROW_WIDTH,
    parameter int bank_width       = ddr_cmd_pkg::DEF_BANK_WIDTH,
    parameter int chip_bits        = ddr_cmd_pkg::DEF_CHIP_BITS,
    parameter int local_addr_width = ddr_cmd_pkg::DEF_LOCAL_ADDR_WIDTH
) (
    input  wire logic [local_addr_width-1:0]            local_addr,
    input  wire ddr_cmd_pkg::addr_order_t               addr_order,
    input  wire logic [ddr_cmd_pkg::CSR_COL_WIDTH-1:0]  col_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_ROW_WIDTH-1:0]  row_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_BANK_WIDTH-1:0] bank_width_csr,
    input  wire logic [ddr_cmd_pkg::OFS_WIDTH-1:0]      col_offset,
    input  wire logic [ddr_cmd_pkg::OFS_WIDTH-1:0]      col_row_offset,
    input  wire logic [ddr_cmd_pkg::OFS_WIDTH-1:0]      col_bank_offset,
    input  wire logic [ddr_cmd_pkg::OFS_WIDTH-1:0]      chip_offset,
    input  wire logic                                   cs_present,
    output logic [chip_bits-1:0]                        map_cs,
    output logic [bank_width-1:0]                       map_bank,
    output logic [row_width-1:0]                        map_row,
    output logic [col_width-1:0]                        map_col
);
    import ddr_cmd_pkg::*;

    logic [OFS_WIDTH-1:0] row_base;  // first local bit of the row field
    logic [OFS_WIDTH-1:0] bank_base;

    // bits past the top of the local address read as zero
    function automatic logic addr_bit(input int idx);
        addr_bit = (idx < local_addr_width) ? local_addr[idx] : 1'b0;
    endfunction

    assign row_base  = (addr_order == ORDER_BANK_ROW) ? col_offset : col_bank_offset;
    assign bank_base = (addr_order == ORDER_BANK_ROW) ? col_row_offset : col_offset;

    ////////////////////////////////////////
    // column field with 4 columns per local beat
    ////////////////////////////////////////
    always_comb
    begin
        map_col = '0;  // low two column bits always zero
        for (int n = BEAT_SHIFT; n < col_width; n++)
        begin
            if (n < int'(col_width_csr))
                map_col[n] = local_addr[n - BEAT_SHIFT];
        end
    end

    always_comb
    begin
        map_row = '0;
        for (int j = 0; j < row_width; j++)
        begin
            if (j < int'(row_width_csr))
                map_row[j] = addr_bit(j + int'(row_base));
        end
    end

    always_comb
    begin
        map_bank = '0;
        for (int k = 0; k < bank_width; k++)
        begin
            if (k < int'(bank_width_csr))
                map_bank[k] = addr_bit(k + int'(bank_base));
        end
    end

    // chip field sits above everything else
    always_comb
    begin
        map_cs = '0;
        if (cs_present)
        begin
            for (int m = 0; m < chip_bits; m++)
                map_cs[m] = addr_bit(m + int'(chip_offset));
        end
    end

endmodule

`default_nettype wire

/* src/burst_addr_counter.sv */
// burst_addr_counter
// current burst address, loaded from the mapper on accept and
// stepped one burst per taken command with wrap and carry

`default_nettype none

module burst_addr_counter #(
    parameter int col_width  = ddr_cmd_pkg::DEF_COL_WIDTH,
    parameter int row_width  = ddr_cmd_pkg::DEF_ROW_WIDTH,
    parameter int bank_width = ddr_cmd_pkg::DEF_BANK_WIDTH,
    parameter int chip_bits  = ddr_cmd_pkg::DEF_CHIP_BITS
) (
    input  wire logic                     ctl_clk,
    input  wire logic                     ctl_reset_n,
    input  wire logic                     load,
    input  wire logic                     step,
    input  wire ddr_cmd_pkg::addr_order_t addr_order,
    input  wire logic [col_width-1:0]     max_col,
    input  wire logic [row_width-1:0]     max_row,
    input  wire logic [bank_width-1:0]    max_bank,
    input  wire logic [chip_bits-1:0]     max_chip,
    input  wire logic [chip_bits-1:0]     map_cs,
    input  wire logic [bank_width-1:0]    map_bank,
    input  wire logic [row_width-1:0]     map_row,
    input  wire logic [col_width-1:0]     map_col,
    output logic [chip_bits-1:0]          cur_cs,
    output logic [bank_width-1:0]         cur_bank,
    output logic [row_width-1:0]          cur_row,
    output logic [col_width-1:0]          cur_col
);
    import ddr_cmd_pkg::*;

    logic [col_width-BURST_SHIFT-1:0] col_burst;  // column in units of one burst
    logic                             col_wrap;
    logic [row_width-1:0]             row_next;
    logic [bank_width-1:0]            bank_next;
    logic [chip_bits-1:0]             cs_next;

    assign col_burst = cur_col[col_width-1:BURST_SHIFT];
    assign col_wrap  = (col_burst == max_col[col_width-1:BURST_SHIFT]);
    assign row_next  = (cur_row == max_row) ? '0 : cur_row + 1'b1;
    assign bank_next = (cur_bank == max_bank) ? '0 : cur_bank + 1'b1;
    assign cs_next   = (cur_cs == max_chip) ? '0 : cur_cs + 1'b1;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            cur_cs   <= '0;
            cur_bank <= '0;
            cur_row  <= '0;
            cur_col  <= '0;
        end
        else if (load)
        begin
            cur_cs   <= map_cs & max_chip;  // chip bits above the csr width stay clear
            cur_bank <= map_bank;
            cur_row  <= map_row;
            cur_col  <= map_col;
        end
        else if (step)
        begin
            if (!col_wrap)
                cur_col[col_width-1:BURST_SHIFT] <= col_burst + 1'b1;
            else
            begin
                cur_col[col_width-1:BURST_SHIFT] <= '0;
                if (addr_order == ORDER_BANK_ROW)  // row, then bank, then chip
                begin
                    cur_row <= row_next;
                    if (cur_row == max_row)
                    begin
                        cur_bank <= bank_next;
                        if (cur_bank == max_bank)
                            cur_cs <= cs_next;
                    end
                end
                else  // bank, then row, then chip
                begin
                    cur_bank <= bank_next;
                    if (cur_bank == max_bank)
                    begin
                        cur_row <= row_next;
                        if (cur_row == max_row)
                            cur_cs <= cs_next;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/burst_splitter.sv */
// burst_splitter
// accepts local requests, counts down the remaining beats and
// drives the registered command strobes under back-pressure

`default_nettype none

module burst_splitter (
    input  wire logic                               ctl_clk,
    input  wire logic                               ctl_reset_n,
    input  wire logic                               local_read_req,
    input  wire logic                               local_write_req,
    input  wire logic [ddr_cmd_pkg::SIZE_WIDTH-1:0] local_size,
    input  wire logic                               local_autopch_req,
    input  wire logic                               ready_in,
    output logic                                    ready_out,
    output logic                                    load,
    output logic                                    step,
    output logic                                    read_req,
    output logic                                    write_req,
    output ddr_cmd_pkg::cmd_size_t                  size,
    output logic                                    autopch_req
);
    import ddr_cmd_pkg::*;

    logic                  accept;
    logic [SIZE_WIDTH-1:0] beats;     // request size, zero taken as one
    logic [SIZE_WIDTH-1:0] rem;       // beats left including the current command
    logic [SIZE_WIDTH-1:0] rem_next;

    // beats carried by a command given the beats still to go
    function automatic cmd_size_t cmd_beats(input logic [SIZE_WIDTH-1:0] left);
        cmd_beats = (left >= SIZE_WIDTH'(BEATS_PER_BURST)) ? cmd_size_t'(BEATS_PER_BURST)
                                                          : cmd_size_t'(1);
    endfunction

    assign accept   = ready_out && (local_read_req || local_write_req);
    assign load     = accept;
    assign step     = (read_req || write_req) && ready_in;  // command taken
    assign beats    = (local_size == '0) ? SIZE_WIDTH'(1) : local_size;
    assign rem_next = rem - SIZE_WIDTH'(BEATS_PER_BURST);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            ready_out   <= 1'b1;
            read_req    <= 1'b0;
            write_req   <= 1'b0;
            autopch_req <= 1'b0;
            size        <= '0;
            rem         <= '0;
        end
        else if (accept)
        begin
            ready_out   <= 1'b0;
            read_req    <= local_read_req;
            write_req   <= !local_read_req;
            autopch_req <= local_autopch_req;  // same flag on every command
            size        <= cmd_beats(beats);
            rem         <= beats;
        end
        else if (step)
        begin
            if (rem > SIZE_WIDTH'(BEATS_PER_BURST))
            begin
                rem  <= rem_next;
                size <= cmd_beats(rem_next);
            end
            else  // last command taken
            begin
                read_req    <= 1'b0;
                write_req   <= 1'b0;
                autopch_req <= 1'b0;
                ready_out   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/ddr_cmd_gen.sv */
// ddr_cmd_gen
// top level: csr geometry, address mapper, burst address counter
// and burst splitter

`default_nettype none

module ddr_cmd_gen #(
    parameter int col_width        = ddr_cmd_pkg::DEF_COL_WIDTH,
    parameter int row_width        = ddr_cmd_pkg::DEF_ROW_WIDTH,
    parameter int bank_width       = ddr_cmd_pkg::DEF_BANK_WIDTH,
    parameter int chip_bits        = ddr_cmd_pkg::DEF_CHIP_BITS,
    parameter int local_addr_width = ddr_cmd_pkg::DEF_LOCAL_ADDR_WIDTH
) (
    input  wire logic                                   ctl_clk,
    input  wire logic                                   ctl_reset_n,
    input  wire logic                                   local_read_req,
    input  wire logic                                   local_write_req,
    input  wire logic [ddr_cmd_pkg::SIZE_WIDTH-1:0]     local_size,
    input  wire logic [local_addr_width-1:0]            local_addr,
    input  wire logic                                   local_autopch_req,
    input  wire ddr_cmd_pkg::addr_order_t               addr_order,
    input  wire logic [ddr_cmd_pkg::CSR_COL_WIDTH-1:0]  col_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_ROW_WIDTH-1:0]  row_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_BANK_WIDTH-1:0] bank_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_CS_WIDTH-1:0]   cs_width_csr,
    input  wire logic                                   ready_in,
    output logic                                        ready_out,
    output logic                                        read_req,
    output logic                                        write_req,
    output ddr_cmd_pkg::cmd_size_t                      size,
    output logic                                        autopch_req,
    output logic [chip_bits-1:0]                        cs_addr,
    output logic [bank_width-1:0]                       bank_addr,
    output logic [row_width-1:0]                        row_addr,
    output logic [col_width-1:0]                        col_addr
);
    import ddr_cmd_pkg::*;

    logic [OFS_WIDTH-1:0]  col_offset;
    logic [OFS_WIDTH-1:0]  col_row_offset;
    logic [OFS_WIDTH-1:0]  col_bank_offset;
    logic [OFS_WIDTH-1:0]  chip_offset;
    logic [col_width-1:0]  max_col;
    logic [row_width-1:0]  max_row;
    logic [bank_width-1:0] max_bank;
    logic [chip_bits-1:0]  max_chip;
    logic                  cs_present;
    logic [chip_bits-1:0]  map_cs;
    logic [bank_width-1:0] map_bank;
    logic [row_width-1:0]  map_row;
    logic [col_width-1:0]  map_col;
    logic                  load;
    logic                  step;

    csr_geometry #(
        .col_width(col_width), .row_width(row_width),
        .bank_width(bank_width), .chip_bits(chip_bits)
    ) geom0 (
        .ctl_clk, .ctl_reset_n, .col_width_csr, .row_width_csr, .bank_width_csr,
        .cs_width_csr, .col_offset, .col_row_offset, .col_bank_offset, .chip_offset,
        .max_col, .max_row, .max_bank, .max_chip, .cs_present
    );

    addr_mapper #(
        .col_width(col_width), .row_width(row_width), .bank_width(bank_width),
        .chip_bits(chip_bits), .local_addr_width(local_addr_width)
    ) map0 (
        .local_addr, .addr_order, .col_width_csr, .row_width_csr, .bank_width_csr,
        .col_offset, .col_row_offset, .col_bank_offset, .chip_offset, .cs_present,
        .map_cs, .map_bank, .map_row, .map_col
    );

    // the current burst address is the command address
    burst_addr_counter #(
        .col_width(col_width), .row_width(row_width),
        .bank_width(bank_width), .chip_bits(chip_bits)
    ) cnt0 (
        .ctl_clk, .ctl_reset_n, .load, .step, .addr_order,
        .max_col, .max_row, .max_bank, .max_chip,
        .map_cs, .map_bank, .map_row, .map_col,
        .cur_cs(cs_addr), .cur_bank(bank_addr), .cur_row(row_addr), .cur_col(col_addr)
    );

    burst_splitter split0 (
        .ctl_clk, .ctl_reset_n, .local_read_req, .local_write_req, .local_size,
        .local_autopch_req, .ready_in, .ready_out, .load, .step,
        .read_req, .write_req, .size, .autopch_req
    );

endmodule

`default_nettype wire

/* test/cmd_checker.sv */
// cmd_checker
// reference model of address mapping, burst split and burst step,
// expected command queue, result line per test and closing summary

`default_nettype none

module cmd_checker (
    input  wire logic                                          ctl_clk,
    input  wire logic                                          ctl_reset_n,
    input  wire logic                                          local_read_req,
    input  wire logic                                          local_write_req,
    input  wire logic [ddr_cmd_pkg::SIZE_WIDTH-1:0]            local_size,
    input  wire logic [ddr_cmd_pkg::DEF_LOCAL_ADDR_WIDTH-1:0]  local_addr,
    input  wire logic                                          local_autopch_req,
    input  wire ddr_cmd_pkg::addr_order_t                      addr_order,
    input  wire logic [ddr_cmd_pkg::CSR_COL_WIDTH-1:0]         col_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_ROW_WIDTH-1:0]         row_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_BANK_WIDTH-1:0]        bank_width_csr,
    input  wire logic [ddr_cmd_pkg::CSR_CS_WIDTH-1:0]          cs_width_csr,
    input  wire logic                                          ready_in,
    input  wire logic                                          ready_out,
    input  wire logic                                          read_req,
    input  wire logic                                          write_req,
    input  wire ddr_cmd_pkg::cmd_size_t                        size,
    input  wire logic                                          autopch_req,
    input  wire logic [ddr_cmd_pkg::DEF_CHIP_BITS-1:0]         cs_addr,
    input  wire logic [ddr_cmd_pkg::DEF_BANK_WIDTH-1:0]        bank_addr,
    input  wire logic [ddr_cmd_pkg::DEF_ROW_WIDTH-1:0]         row_addr,
    input  wire logic [ddr_cmd_pkg::DEF_COL_WIDTH-1:0]         col_addr,
    input  wire logic [31:0]                                   test_num,
    input  wire logic                                          test_end,
    input  wire logic                                          run_end,
    output int                                                 fail_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import ddr_cmd_pkg::*;

    // kind, size, autopch, then chip, bank, row, column
    localparam int CMD_W = 4 + DEF_CHIP_BITS + DEF_BANK_WIDTH + DEF_ROW_WIDTH + DEF_COL_WIDTH;

    logic [CMD_W-1:0] expect_q[$];
    logic [CMD_W-1:0] seen;
    logic [CMD_W-1:0] prev_seen;
    logic [CMD_W-1:0] exp_cmd;
    logic             prev_hold = 1'b0;  // command held back on the last edge
    int               test_errs = 0;
    int               test_cmds = 0;
    int               total_errs = 0;
    int               total_cmds = 0;
    int               tests_done = 0;

    function automatic longint unsigned ones(input int w);
        return (64'd1 << w) - 64'd1;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        test_errs++;
        total_errs++;
    endtask

    // lowest field first and each one wraps at all ones into the next
    task automatic carry(inout longint unsigned lo, input int lw,
                         inout longint unsigned mid, input int mw,
                         inout longint unsigned hi, input int hw);
        if (lo != ones(lw))
            lo = lo + 64'd1;
        else
        begin
            lo = 64'd0;
            if (mid != ones(mw))
                mid = mid + 64'd1;
            else
            begin
                mid = 64'd0;
                hi  = (hi == ones(hw)) ? 64'd0 : hi + 64'd1;
            end
        end
    endtask

    ////////////////////////////////////////
    // expected commands of one request
    ////////////////////////////////////////
    task automatic push_request(input logic is_read, input longint unsigned addr,
                                input int beats, input logic apch);
        int              c;
        int              r;
        int              b;
        int              s;
        int              left;
        longint unsigned col;
        longint unsigned row;
        longint unsigned bank;
        longint unsigned cs;
        cmd_size_t       sz;
        c    = int'(col_width_csr);
        r    = int'(row_width_csr);
        b    = int'(bank_width_csr);
        s    = int'(cs_width_csr);
        col  = (addr & ones(c - 2)) << 2;  // one beat is 4 columns
        if (addr_order == ORDER_BANK_ROW)
        begin
            row  = (addr >> (c - 2)) & ones(r);
            bank = (addr >> (c - 2 + r)) & ones(b);
        end
        else
        begin
            bank = (addr >> (c - 2)) & ones(b);
            row  = (addr >> (c - 2 + b)) & ones(r);
        end
        cs   = (addr >> (c - 2 + r + b)) & ones(s);
        left = (beats == 0) ? 1 : beats;
        while (left > 0)
        begin
            sz = (left >= 2) ? 2'd2 : 2'd1;
            expect_q.push_back({is_read, sz, apch, DEF_CHIP_BITS'(cs), DEF_BANK_WIDTH'(bank),
                                DEF_ROW_WIDTH'(row), DEF_COL_WIDTH'(col)});
            left = left - 2;
            if ((col >> 3) != (ones(c) >> 3))
                col = col + 64'd8;  // next burst of 8 columns
            else
            begin
                col = col & 64'd7;
                if (addr_order == ORDER_BANK_ROW)
                    carry(row, r, bank, b, cs, s);
                else
                    carry(bank, b, row, r, cs, s);
            end
        end
    endtask

    always @(negedge ctl_clk)
    begin
        seen = {read_req, size, autopch_req, cs_addr, bank_addr, row_addr, col_addr};
        if (!ctl_reset_n)
        begin
            if (read_req || write_req || autopch_req || !ready_out || seen[CMD_W-5:0] != '0)
                report_error("outputs are not in their reset state");
            prev_hold = 1'b0;
        end
        else
        begin
            if (read_req && write_req)
                report_error("read and write strobes are both high");
            if (ready_out == (read_req || write_req))
                report_error("ready_out does not match the command state");
            if (prev_hold && seen != prev_seen)
                report_error("command changed while ready_in was low");
            if ((read_req || write_req) && ready_in)  // taken on the next edge
            begin
                test_cmds++;
                total_cmds++;
                if (expect_q.size() == 0)
                    report_error("a command appeared with none expected");
                else
                begin
                    exp_cmd = expect_q.pop_front();
                    if (seen != exp_cmd)
                        report_error($sformatf("command expected %h, got %h", exp_cmd, seen));
                end
            end
            prev_hold = (read_req || write_req) && !ready_in;
            prev_seen = seen;
            if (ready_out && (local_read_req || local_write_req))
                push_request(local_read_req, 64'(local_addr), int'(local_size), local_autopch_req);
            if (test_end)
            begin
                $display("test %0d: %0d commands, %0d errors, %s", test_num, test_cmds,
                         test_errs, (test_errs == 0) ? "ok" : "failed");
                tests_done++;
                test_cmds = 0;
                test_errs = 0;
            end
        end
        fail_count = total_errs + expect_q.size();
        if (run_end)
            $display("summary: %0d tests, %0d commands, %0d errors, %0d commands missing",
                     tests_done, total_cmds, total_errs, expect_q.size());
    end

endmodule

`default_nettype wire

/* test/tb_ddr_cmd_gen.sv */
// tb_ddr_cmd_gen
// clock and reset, csr setup, seeded random requests, test sequence,
// ddr_cmd_gen instance and the command checker

`default_nettype none

module tb_ddr_cmd_gen;
    timeunit 1ns;
    timeprecision 100ps;
    import ddr_cmd_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int REQ_COUNT [NUM_TESTS] = '{6, 6, 12, 16, 10};
    localparam int MAX_BEATS [NUM_TESTS] = '{2, 2, 40, 40, 40};

    logic                            ctl_clk;
    logic                            ctl_reset_n;
    logic                            local_read_req;
    logic                            local_write_req;
    logic [SIZE_WIDTH-1:0]           local_size;
    logic [DEF_LOCAL_ADDR_WIDTH-1:0] local_addr;
    logic                            local_autopch_req;
    addr_order_t                     addr_order;
    logic [CSR_COL_WIDTH-1:0]        col_width_csr;
    logic [CSR_ROW_WIDTH-1:0]        row_width_csr;
    logic [CSR_BANK_WIDTH-1:0]       bank_width_csr;
    logic [CSR_CS_WIDTH-1:0]         cs_width_csr;
    logic                            ready_in;
    logic                            ready_out;
    logic                            read_req;
    logic                            write_req;
    cmd_size_t                       size;
    logic                            autopch_req;
    logic [DEF_CHIP_BITS-1:0]        cs_addr;
    logic [DEF_BANK_WIDTH-1:0]       bank_addr;
    logic [DEF_ROW_WIDTH-1:0]        row_addr;
    logic [DEF_COL_WIDTH-1:0]        col_addr;
    logic [31:0]                     test_num;
    logic                            test_end;
    logic                            run_end;
    int                              fail_count;
    integer                          seed = 88;
    logic                            stall;  // random ready_in low
    int                              cycles;

    ddr_cmd_gen dut0 (.*);
    cmd_checker chk0 (.*);

    always #50 ctl_clk = ~ctl_clk;

    always @(posedge ctl_clk)
    begin
        #1;
        ready_in = stall ? (($random(seed) & 3) != 0) : 1'b1;
    end

    // 4 cycles per command at the largest sizes, 50 per test
    function automatic int timeout_cycles();
        int total;
        total = 10;
        for (int t = 0; t < NUM_TESTS; t++)
            total += 4 * REQ_COUNT[t] * ((MAX_BEATS[t] + 1) / 2) + 50;
        return total;
    endfunction

    task automatic wait_idle();
        while (!ready_out)
        begin
            @(posedge ctl_clk);
            #1;
        end
    endtask

    task automatic set_geometry(input addr_order_t order, input int c, input int r,
                                input int b, input int s);
        wait_idle();
        addr_order     = order;
        col_width_csr  = CSR_COL_WIDTH'(c);
        row_width_csr  = CSR_ROW_WIDTH'(r);
        bank_width_csr = CSR_BANK_WIDTH'(b);
        cs_width_csr   = CSR_CS_WIDTH'(s);
        repeat (3) @(posedge ctl_clk);
        #1;
    endtask

    ////////////////////////////////////////
    // request stimulus
    ////////////////////////////////////////
    task automatic random_requests(input int count, input int max_beats, input logic near_top);
        logic [DEF_LOCAL_ADDR_WIDTH-1:0] addr;
        int                              cb;
        for (int i = 0; i < count; i++)
        begin
            cb   = int'(col_width_csr) - BEAT_SHIFT;
            addr = DEF_LOCAL_ADDR_WIDTH'({$random(seed), $random(seed)});
            if (near_top)
            begin
                // column just below its top, row and bank often all ones
                addr = (addr >> cb << cb) | ((33'd1 << cb) - 33'd2 - 33'(2 * ($random(seed) & 3)));
                if (($random(seed) & 1) != 0)
                    addr = addr | (((33'd1 << (row_width_csr + bank_width_csr)) - 33'd1) << cb);
            end
            addr[0] = 1'b0;
            wait_idle();
            local_read_req    = (($random(seed) & 1) != 0);
            local_write_req   = !local_read_req;
            local_size        = SIZE_WIDTH'(1 + (($random(seed) & 32'h7fff_ffff) % max_beats));
            local_addr        = addr;
            local_autopch_req = (($random(seed) & 1) != 0);
            @(posedge ctl_clk);
            #1;
            local_read_req  = 1'b0;
            local_write_req = 1'b0;
        end
    endtask

    task automatic finish_test();
        wait_idle();
        test_end = 1'b1;
        @(posedge ctl_clk);
        #1;
        test_end = 1'b0;
        test_num = test_num + 1;
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < timeout_cycles())
        begin
            @(posedge ctl_clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        ctl_clk           = 1'b0;
        ctl_reset_n       = 1'b0;
        local_read_req    = 1'b0;
        local_write_req   = 1'b0;
        local_size        = '0;
        local_addr        = '0;
        local_autopch_req = 1'b0;
        addr_order        = ORDER_ROW_BANK;
        col_width_csr     = 4'd10;
        row_width_csr     = 5'd14;
        bank_width_csr    = 2'd3;
        cs_width_csr      = 2'd2;
        ready_in          = 1'b1;
        stall             = 1'b0;
        test_num          = 1;
        test_end          = 1'b0;
        run_end           = 1'b0;
        repeat (5) @(posedge ctl_clk);
        #1;
        ctl_reset_n = 1'b1;

        set_geometry(ORDER_ROW_BANK, 10, 14, 3, 2);  // short requests
        random_requests(REQ_COUNT[0], MAX_BEATS[0], 1'b0);
        finish_test();
        set_geometry(ORDER_BANK_ROW, 9, 13, 2, 0);   // no chip field
        random_requests(REQ_COUNT[1], MAX_BEATS[1], 1'b0);
        finish_test();
        set_geometry(ORDER_ROW_BANK, 12, 16, 3, 2);  // long requests
        random_requests(REQ_COUNT[2], MAX_BEATS[2], 1'b0);
        finish_test();
        // wrap and carry in both orders
        set_geometry(ORDER_ROW_BANK, 8, 2, 1, 1);
        random_requests(REQ_COUNT[3] / 2, MAX_BEATS[3], 1'b1);
        set_geometry(ORDER_BANK_ROW, 8, 2, 1, 2);
        random_requests(REQ_COUNT[3] / 2, MAX_BEATS[3], 1'b1);
        finish_test();
        stall = 1'b1;
        set_geometry(ORDER_BANK_ROW, 11, 15, 3, 2);
        random_requests(REQ_COUNT[4], MAX_BEATS[4], 1'b0);
        finish_test();
        stall = 1'b0;

        run_end = 1'b1;
        @(posedge ctl_clk);
        #1;
        run_end = 1'b0;
        if (fail_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
src/ddr_cmd_pkg.sv
src/csr_geometry.sv
src/addr_mapper.sv
src/burst_addr_counter.sv
src/burst_splitter.sv
src/ddr_cmd_gen.sv
test/cmd_checker.sv
test/tb_ddr_cmd_gen.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing
TOP      = tb_ddr_cmd_gen
RTL_TOP  = ddr_cmd_gen
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
